// ==== Bender.yml ====
package:
  name: exu_mul

sources:
  - mul_pkg.sv
  - clmul_unit.sv
  - grev_gorc_unit.sv
  - crc_unit.sv
  - bitmanip_unit.sv
  - mul_array.sv
  - exu_mul_top.sv
  - target: simulation
    files:
      - exu_mul_chk.sv
      - exu_mul_tb.sv

// ==== bitmanip_unit.sv ====
/*
 * Bit-manipulation side of the multiply pipeline. Decodes the opcode
 * into carry-less, butterfly and CRC groups, each masked by its build
 * enable, and registers the chosen value with a select bit on a valid
 * request. Disabled or non-bitmanip opcodes register zero.
 */

module bitmanip_unit
#(
   parameter int ENABLE_ZBC = 1,
   parameter int ENABLE_ZBP = 1,
   parameter int ENABLE_ZBR = 1
)
(
   input  logic              clk_i,
   input  logic              reset_i,
   input  mul_pkg::mul_req_t req_i,
   input  mul_pkg::xlen_t    rs1_i,
   input  mul_pkg::xlen_t    rs2_i,
   output logic              sel_o,
   output mul_pkg::xlen_t    result_o
);

   logic           zbc_sel;
   logic           zbp_sel;
   logic           zbr_sel;
   logic           sel_d;
   logic           gorc_mode;
   logic           castagnoli;
   logic [1:0]     crc_size;
   mul_pkg::xlen_t clmul_res;
   mul_pkg::xlen_t clmulh_res;
   mul_pkg::xlen_t clmulr_res;
   mul_pkg::xlen_t grev_res;
   mul_pkg::xlen_t crc_res;
   mul_pkg::xlen_t result_d;

   // Group decode, gated by build enables
   assign zbc_sel = (ENABLE_ZBC != 0) &&
      (req_i.op inside {mul_pkg::OP_CLMUL, mul_pkg::OP_CLMULH, mul_pkg::OP_CLMULR});
   assign zbp_sel = (ENABLE_ZBP != 0) &&
      (req_i.op inside {mul_pkg::OP_GREV, mul_pkg::OP_GORC});
   assign zbr_sel = (ENABLE_ZBR != 0) &&
      (req_i.op inside {mul_pkg::OP_CRC32_B, mul_pkg::OP_CRC32_H, mul_pkg::OP_CRC32_W,
                        mul_pkg::OP_CRC32C_B, mul_pkg::OP_CRC32C_H, mul_pkg::OP_CRC32C_W});

   assign sel_d = zbc_sel | zbp_sel | zbr_sel;

   assign gorc_mode  = (req_i.op == mul_pkg::OP_GORC);
   assign castagnoli = req_i.op inside {mul_pkg::OP_CRC32C_B, mul_pkg::OP_CRC32C_H,
                                        mul_pkg::OP_CRC32C_W};

   // Byte, half or word step count
   always_comb
   begin
      case (req_i.op)
         mul_pkg::OP_CRC32_B, mul_pkg::OP_CRC32C_B: crc_size = 2'd0;
         mul_pkg::OP_CRC32_H, mul_pkg::OP_CRC32C_H: crc_size = 2'd1;
         default:                                   crc_size = 2'd2;
      endcase
   end

   clmul_unit clmul_unit_i
   (
      .rs1_i    (rs1_i),
      .rs2_i    (rs2_i),
      .clmul_o  (clmul_res),
      .clmulh_o (clmulh_res),
      .clmulr_o (clmulr_res)
   );

   grev_gorc_unit grev_gorc_unit_i
   (
      .rs1_i        (rs1_i),
      .shamt_i      (rs2_i[4:0]),
      .or_combine_i (gorc_mode),
      .result_o     (grev_res)
   );

   crc_unit crc_unit_i
   (
      .rs1_i        (rs1_i),
      .castagnoli_i (castagnoli),
      .size_i       (crc_size),
      .result_o     (crc_res)
   );

   // Result mux, zero when no group hits
   always_comb
   begin
      result_d = '0;
      if (zbc_sel)
      begin
         case (req_i.op)
            mul_pkg::OP_CLMULH: result_d = clmulh_res;
            mul_pkg::OP_CLMULR: result_d = clmulr_res;
            default:            result_d = clmul_res;
         endcase
      end
      else if (zbp_sel)
      begin
         result_d = grev_res;
      end
      else if (zbr_sel)
      begin
         result_d = crc_res;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         sel_o    <= 1'b0;
         result_o <= '0;
      end
      else if (req_i.valid)
      begin
         sel_o    <= sel_d;
         result_o <= result_d;
      end
   end

endmodule

// ==== clmul_unit.sv ====
/*
 * Carry-less multiply, combinational. Builds the 63-bit XOR product
 * of the two operands and offers the low, high and reversed views
 * used by CLMUL, CLMULH and CLMULR.
 */

module clmul_unit
(
   input  mul_pkg::xlen_t rs1_i,
   input  mul_pkg::xlen_t rs2_i,
   output mul_pkg::xlen_t clmul_o,
   output mul_pkg::xlen_t clmulh_o,
   output mul_pkg::xlen_t clmulr_o
);

   localparam int W  = mul_pkg::XLEN;
   localparam int PW = 2*W - 1;

   logic [PW-1:0] rs1_wide;
   logic [PW-1:0] clmul_raw;

   assign rs1_wide = {{(W-1){1'b0}}, rs1_i};

   // One shifted copy of rs1 per set bit of rs2
   always_comb
   begin
      clmul_raw = '0;
      for (int i = 0; i < W; i++)
      begin
         if (rs2_i[i])
         begin
            clmul_raw = clmul_raw ^ (rs1_wide << i);
         end
      end
   end

   assign clmul_o  = clmul_raw[W-1:0];

   // Top bit of the high view is always zero
   assign clmulh_o = {1'b0, clmul_raw[PW-1:W]};

   assign clmulr_o = clmul_raw[PW-1:W-1];

endmodule

// ==== crc_unit.sv ====
/*
 * Reflected CRC step, combinational. Shifts rs1 right 8, 16 or 32
 * times, XORing in the CRC32 or Castagnoli polynomial whenever a one
 * drops out. The caller pre-inverts the input as the ISA expects.
 */

module crc_unit
(
   input  mul_pkg::xlen_t rs1_i,
   input  logic           castagnoli_i,
   input  logic [1:0]     size_i,
   output mul_pkg::xlen_t result_o
);

   localparam int W = mul_pkg::XLEN;

   // Size codes
   localparam logic [1:0] SIZE_B = 2'd0;
   localparam logic [1:0] SIZE_H = 2'd1;

   logic [5:0]   steps;
   logic [W-1:0] poly;
   logic [W-1:0] crc;

   always_comb
   begin
      case (size_i)
         SIZE_B:  steps = 6'd8;
         SIZE_H:  steps = 6'd16;
         default: steps = 6'd32;
      endcase
   end

   assign poly = castagnoli_i ? mul_pkg::CRC32C_POLY_REV : mul_pkg::CRC32_POLY_REV;

   // Unrolled to 32 steps, later ones skipped for short sizes
   always_comb
   begin
      crc = rs1_i;
      for (int i = 0; i < W; i++)
      begin
         if (i < steps)
         begin
            crc = (crc >> 1) ^ (poly & {W{crc[0]}});
         end
      end
   end

   assign result_o = crc;

endmodule

// ==== exu_mul_chk.sv ====
/*
 * Concurrent checks on the multiply unit's top level, attached with
 * bind from the testbench. Covers the reset value, the held result
 * over idle cycles and a known opcode on every valid request.
 * Failed assertions are counted for the end-of-run verdict.
 */

module exu_mul_chk
(
   input logic              clk_i,
   input logic              reset_i,
   input mul_pkg::mul_req_t req_i,
   input mul_pkg::xlen_t    result_x_o
);

   // Number of failed assertions
   int error_count = 0;

   // Both result registers clear on reset
   reset_zero: assert property (@(posedge clk_i) reset_i |=> result_x_o == '0)
      else
      begin
         error_count++;
         $error("result_x_o is not zero in the cycle after reset");
      end

   // No capture without valid
   hold_idle: assert property (@(posedge clk_i) disable iff (reset_i)
      !req_i.valid |=> $stable(result_x_o))
      else
      begin
         error_count++;
         $error("result_x_o changed after a cycle with valid low");
      end

   op_known: assert property (@(posedge clk_i) disable iff (reset_i)
      req_i.valid |-> !$isunknown(req_i.op))
      else
      begin
         error_count++;
         $error("req_i.op has unknown bits on a valid request");
      end

endmodule

// ==== exu_mul_tb.sv ====
/*
 * Testbench for the execute-stage multiply unit. Drives random and
 * corner requests, predicts each result from the ISA rules and checks
 * it one cycle after capture, including held values over idle cycles.
 */

module exu_mul_tb;

   localparam int MAX_CYCLES = 3000;

   logic              clk_i = 1'b0;
   logic              reset_i;
   mul_pkg::mul_req_t req_i;
   mul_pkg::xlen_t    rs1_i;
   mul_pkg::xlen_t    rs2_i;
   mul_pkg::xlen_t    result_x_o;

   logic [31:0]      lcg_state = 32'hd7409d49;
   mul_pkg::xlen_t   exp_word;
   mul_pkg::mul_op_e exp_op;
   logic             armed = 1'b0;
   int               cycle_count = 0;
   int               check_count = 0;

   exu_mul_top #(.ENABLE_ZBC(1), .ENABLE_ZBP(1), .ENABLE_ZBR(1)) exu_mul_top_i
   (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .req_i      (req_i),
      .rs1_i      (rs1_i),
      .rs2_i      (rs2_i),
      .result_x_o (result_x_o)
   );

   bind exu_mul_top exu_mul_chk exu_mul_chk_i
   (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .req_i      (req_i),
      .result_x_o (result_x_o)
   );

   always #50 clk_i = ~clk_i;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Expected word straight from the instruction definitions
   function automatic mul_pkg::xlen_t ref_result(mul_pkg::mul_op_e op, logic [31:0] a,
                                                 logic [31:0] b);
      longint      sa;
      longint      sb;
      longint      ua;
      longint      ub;
      logic [63:0] wide;
      logic [31:0] x;
      logic [31:0] lo;
      logic [31:0] sw;
      int          steps;
      sa = $signed(a);
      sb = $signed(b);
      ua = {32'b0, a};
      ub = {32'b0, b};
      wide = '0;
      x = a;
      case (op)
         mul_pkg::OP_MUL:    wide = sa * sb;
         mul_pkg::OP_MULH:   wide = sa * sb;
         mul_pkg::OP_MULHSU: wide = sa * ub;
         mul_pkg::OP_CLMUL, mul_pkg::OP_CLMULH, mul_pkg::OP_CLMULR:
         begin
            for (int i = 0; i < 32; i++)
               if (b[i])
                  wide = wide ^ ({32'b0, a} << i);
         end
         mul_pkg::OP_GREV, mul_pkg::OP_GORC:
         begin
            for (int k = 0; k < 5; k++)
            begin
               // Lower member of each pair of 2**k-bit groups
               for (int i = 0; i < 32; i++)
                  lo[i] = ((i >> k) & 1) == 0;
               sw = ((x & lo) << (1 << k)) | ((x & ~lo) >> (1 << k));
               if (b[k])
                  x = (op == mul_pkg::OP_GORC) ? (x | sw) : sw;
            end
         end
         mul_pkg::OP_CRC32_B, mul_pkg::OP_CRC32_H, mul_pkg::OP_CRC32_W,
         mul_pkg::OP_CRC32C_B, mul_pkg::OP_CRC32C_H, mul_pkg::OP_CRC32C_W:
         begin
            if (op inside {mul_pkg::OP_CRC32_B, mul_pkg::OP_CRC32C_B})
               steps = 8;
            else if (op inside {mul_pkg::OP_CRC32_H, mul_pkg::OP_CRC32C_H})
               steps = 16;
            else
               steps = 32;
            for (int i = 0; i < steps; i++)
               x = (x >> 1) ^ ((x[0] == 1'b1) ? ((op >= mul_pkg::OP_CRC32C_B) ?
                   32'h82f63b78 : 32'hedb88320) : 32'h0);
         end
         default:            wide = ua * ub;
      endcase
      case (op)
         mul_pkg::OP_MUL, mul_pkg::OP_CLMUL: return wide[31:0];
         mul_pkg::OP_CLMULR:                 return wide[62:31];
         mul_pkg::OP_GREV, mul_pkg::OP_GORC: return x;
         default:                            return (op >= mul_pkg::OP_CRC32_B) ? x : wide[63:32];
      endcase
   endfunction

   task automatic stop_on_error(string msg);
      $display("Error at time %0t: %s", $time, msg);
      $display("TESTBENCH FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic send(mul_pkg::mul_op_e op, logic [31:0] a, logic [31:0] b);
      @(posedge clk_i);
      req_i.valid <= 1'b1;
      req_i.op    <= op;
      rs1_i       <= a;
      rs2_i       <= b;
   endtask

   // Operands keep changing while idle, the result must not
   task automatic idle(int n);
      repeat (n)
      begin
         @(posedge clk_i);
         req_i.valid <= 1'b0;
         rs1_i       <= lcg_next();
         rs2_i       <= lcg_next();
      end
   endtask

   // Output settled after the capturing edge, inputs settled for the next one
   always @(negedge clk_i)
   begin
      if (armed)
      begin
         check_count++;
         assert (result_x_o === exp_word)
         else
            stop_on_error($sformatf("%s gave %h, expected %h", exp_op.name(),
                                    result_x_o, exp_word));
      end
      if (reset_i)
      begin
         exp_word = '0;
         armed    = 1'b1;
      end
      else if (req_i.valid)
      begin
         exp_op   = req_i.op;
         exp_word = ref_result(req_i.op, rs1_i, rs2_i);
      end
   end

   always @(posedge clk_i)
   begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES)
      begin
         $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
         $display("TESTBENCH FAILED");
         $fatal(1, "Simulation stopped by the cycle limit");
      end
   end

   initial
   begin
      logic [31:0] corner [3];
      logic [31:0] a;
      logic [31:0] b;
      corner[0] = 32'hffffffff;
      corner[1] = 32'h80000000;
      corner[2] = 32'h00000000;
      reset_i = 1'b1;
      req_i   = '0;
      rs1_i   = '0;
      rs2_i   = '0;
      repeat (10) @(posedge clk_i);
      reset_i <= 1'b0;
      idle(3);

      // Known CRC vectors pin down the reference itself
      assert (ref_result(mul_pkg::OP_CRC32_B, 32'hffffff9e, '0) == 32'h174841bc)
      else
         stop_on_error("CRC32_B reference does not match the known vector");
      assert (ref_result(mul_pkg::OP_CRC32C_W, 32'h9e9e9e9e, '0) == 32'h95ad114f)
      else
         stop_on_error("CRC32C_W reference does not match the known vector");

      for (int i = 0; i < 400; i++)
         send(mul_pkg::mul_op_e'(i % 4), lcg_next(), lcg_next());
      for (int i = 0; i < 3; i++)
         for (int j = 0; j < 3; j++)
            for (int k = 0; k < 4; k++)
               send(mul_pkg::mul_op_e'(k), corner[i], corner[j]);

      for (int i = 0; i < 300; i++)
      begin
         a = lcg_next();
         b = lcg_next();
         for (int k = 4; k < 7; k++)
            send(mul_pkg::mul_op_e'(k), a, b);
      end

      // Upper rs2 bits are random and must be ignored
      for (int s = 0; s < 32; s++)
         for (int r = 0; r < 4; r++)
         begin
            a = lcg_next();
            b = lcg_next();
            b[4:0] = s[4:0];
            send(mul_pkg::OP_GREV, a, b);
            send(mul_pkg::OP_GORC, a, b);
         end

      send(mul_pkg::OP_CRC32_B, 32'hffffff9e, '0);
      send(mul_pkg::OP_CRC32C_W, 32'h9e9e9e9e, '0);
      for (int i = 0; i < 300; i++)
         send(mul_pkg::mul_op_e'(9 + i % 6), lcg_next(), lcg_next());

      // Mixed opcodes, back to back or with idle gaps
      for (int i = 0; i < 120; i++)
      begin
         send(mul_pkg::mul_op_e'((lcg_next() >> 16) % 15), lcg_next(), lcg_next());
         idle((lcg_next() >> 16) % 4);
      end

      idle(2);
      if (check_count > 0 && exu_mul_top_i.exu_mul_chk_i.error_count == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// ==== exu_mul_top.sv ====
/*
 * Execute-stage multiply unit with the bit-manipulation operations
 * that share its pipeline register. A request is taken when its valid
 * bit is high and the result appears one cycle later, held until the
 * next request. Group enables are set here and passed down.
 */

module exu_mul_top
#(
   parameter int ENABLE_ZBC = 1,
   parameter int ENABLE_ZBP = 1,
   parameter int ENABLE_ZBR = 1
)
(
   input  logic              clk_i,
   input  logic              reset_i,
   input  mul_pkg::mul_req_t req_i,
   input  mul_pkg::xlen_t    rs1_i,
   input  mul_pkg::xlen_t    rs2_i,
   output mul_pkg::xlen_t    result_x_o
);

   mul_pkg::xlen_t product_x;
   mul_pkg::xlen_t bitmanip_x;
   logic           bitmanip_sel_x;

   // Integer multiply path
   mul_array mul_array_i
   (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .req_i     (req_i),
      .rs1_i     (rs1_i),
      .rs2_i     (rs2_i),
      .product_o (product_x)
   );

   // Carry-less multiply, butterfly and CRC path
   bitmanip_unit
   #(
      .ENABLE_ZBC (ENABLE_ZBC),
      .ENABLE_ZBP (ENABLE_ZBP),
      .ENABLE_ZBR (ENABLE_ZBR)
   )
   bitmanip_unit_i
   (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .req_i    (req_i),
      .rs1_i    (rs1_i),
      .rs2_i    (rs2_i),
      .sel_o    (bitmanip_sel_x),
      .result_o (bitmanip_x)
   );

   // Registered select picks the path
   assign result_x_o = bitmanip_sel_x ? bitmanip_x : product_x;

endmodule

// ==== grev_gorc_unit.sv ====
/*
 * Generalized reverse and or-combine, combinational. Five butterfly
 * stages swap neighbouring groups of 1, 2, 4, 8 and 16 bits when the
 * matching shift-amount bit is set. In or-combine mode each stage ORs
 * the swapped word into its input.
 */

module grev_gorc_unit
(
   input  mul_pkg::xlen_t rs1_i,
   input  logic [4:0]     shamt_i,
   input  logic           or_combine_i,
   output mul_pkg::xlen_t result_o
);

   localparam int W       = mul_pkg::XLEN;
   localparam int NSTAGES = 5;

   // Lower half of each group pair, stage 0 first
   localparam logic [NSTAGES-1:0][W-1:0] STAGE_MASK =
   {
      32'h0000ffff,
      32'h00ff00ff,
      32'h0f0f0f0f,
      32'h33333333,
      32'h55555555
   };

   logic [NSTAGES:0][W-1:0] stage;

   assign stage[0] = rs1_i;

   for (genvar k = 0; k < NSTAGES; k++)
   begin : g_stage
      logic [W-1:0] swapped;

      assign swapped = ((stage[k] &  STAGE_MASK[k]) << (2**k)) |
                       ((stage[k] & ~STAGE_MASK[k]) >> (2**k));

      always_comb
      begin
         if (!shamt_i[k])
         begin
            stage[k+1] = stage[k];
         end
         else if (or_combine_i)
         begin
            stage[k+1] = stage[k] | swapped;
         end
         else
         begin
            stage[k+1] = swapped;
         end
      end
   end

   assign result_o = stage[NSTAGES];

endmodule

// ==== mul_array.sv ====
/*
 * Integer multiply datapath. Sign-extends both operands to 33 bits
 * from the opcode, registers them on a valid request and returns the
 * low or high half of the 66-bit signed product in the next cycle.
 */

module mul_array
(
   input  logic              clk_i,
   input  logic              reset_i,
   input  mul_pkg::mul_req_t req_i,
   input  mul_pkg::xlen_t    rs1_i,
   input  mul_pkg::xlen_t    rs2_i,
   output mul_pkg::xlen_t    product_o
);

   localparam int W = mul_pkg::XLEN;

   logic                 rs1_sign;
   logic                 rs2_sign;
   logic                 low_d;
   logic signed [W:0]    rs1_ext;
   logic signed [W:0]    rs2_ext;
   logic signed [W:0]    rs1_x;
   logic signed [W:0]    rs2_x;
   logic                 low_x;
   logic signed [2*W+1:0] prod_x;

   // Other opcodes fall through as unsigned, high half
   always_comb
   begin
      rs1_sign = 1'b0;
      rs2_sign = 1'b0;
      low_d    = 1'b0;
      case (req_i.op)
         mul_pkg::OP_MUL:
         begin
            rs1_sign = 1'b1;
            rs2_sign = 1'b1;
            low_d    = 1'b1;
         end
         mul_pkg::OP_MULH:
         begin
            rs1_sign = 1'b1;
            rs2_sign = 1'b1;
         end
         mul_pkg::OP_MULHSU:
         begin
            rs1_sign = 1'b1;
         end
         default:
         begin
         end
      endcase
   end

   assign rs1_ext = {rs1_sign & rs1_i[W-1], rs1_i};
   assign rs2_ext = {rs2_sign & rs2_i[W-1], rs2_i};

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         rs1_x <= '0;
         rs2_x <= '0;
         low_x <= 1'b0;
      end
      else if (req_i.valid)
      begin
         rs1_x <= rs1_ext;
         rs2_x <= rs2_ext;
         low_x <= low_d;
      end
   end

   // Both factors widen to 66 bits before the multiply
   assign prod_x = rs1_x * rs2_x;

   assign product_o = low_x ? prod_x[W-1:0] : prod_x[2*W-1:W];

endmodule

// ==== mul_pkg.sv ====
/*
 * Shared types and constants for the execute-stage multiply unit.
 * Holds the operand width, the opcode enum, the request struct and
 * the reflected CRC polynomials. Modules refer to these by scoped name.
 */

package mul_pkg;

   // Operand and result width
   localparam int XLEN = 32;

   typedef logic [XLEN-1:0] xlen_t;

   // Operations handled by the multiply pipeline register
   typedef enum logic [3:0]
   {
      OP_MUL      = 4'd0,
      OP_MULH     = 4'd1,
      OP_MULHSU   = 4'd2,
      OP_MULHU    = 4'd3,
      OP_CLMUL    = 4'd4,
      OP_CLMULH   = 4'd5,
      OP_CLMULR   = 4'd6,
      OP_GREV     = 4'd7,
      OP_GORC     = 4'd8,
      OP_CRC32_B  = 4'd9,
      OP_CRC32_H  = 4'd10,
      OP_CRC32_W  = 4'd11,
      OP_CRC32C_B = 4'd12,
      OP_CRC32C_H = 4'd13,
      OP_CRC32C_W = 4'd14
   } mul_op_e;

   // Request strobe and opcode, sampled every cycle
   typedef struct packed
   {
      logic    valid;
      mul_op_e op;
   } mul_req_t;

   // Bit reverse of 32'h04c11db7
   localparam logic [31:0] CRC32_POLY_REV  = 32'hedb88320;

   // Castagnoli, bit reverse of 32'h1edc6f41
   localparam logic [31:0] CRC32C_POLY_REV = 32'h82f63b78;

endpackage

// ==== vlog.f ====
mul_pkg.sv
clmul_unit.sv
grev_gorc_unit.sv
crc_unit.sv
bitmanip_unit.sv
mul_array.sv
exu_mul_top.sv
exu_mul_chk.sv
exu_mul_tb.sv
